//--- Makefile
VERILATOR ?= verilator
VFLAGS    := --timing --assert
TOP       := turf_udp_wrap_tb
FILELIST  := list.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := *** TEST PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- list.f
+incdir+rtl
rtl/turf_udp_pkg.sv
rtl/udp_port_switch.sv
rtl/turf_udp_rdwr.sv
rtl/turf_event_ctrl_port.sv
rtl/turf_acknack_port.sv
rtl/udp_reply_mux.sv
rtl/turf_udp_wrap.sv
test/turf_udp_wrap_checker.sv
test/turf_udp_wrap_tb.sv

//--- rtl/turf_acknack_port.sv
`timescale 1ns/1ps
`include "turf_udp_consts.svh"

module turf_acknack_port #(
    parameter logic [`TURF_PAYLOAD_W-1:0] CHECK_BITS = `TURF_ACK_CHECK,
    parameter turf_udp_pkg::route_e       MY_ROUTE   = turf_udp_pkg::ROUTE_ACK
) (
    input  logic                   aclk_i,
    input  logic                   arst_n_i,
    input  logic                   route_valid_i,
    input  turf_udp_pkg::route_e   route_i,
    input  turf_udp_pkg::payload_t route_data_i,
    input  logic                   event_open_i,
    output logic                   reply_valid_o,
    output turf_udp_pkg::port_t    reply_port_o,
    output turf_udp_pkg::payload_t reply_data_o,
    output logic                   acknack_valid_o,
    output logic [`TURF_ACK_W-1:0] acknack_data_o
);

    logic req;
    logic accept;

    assign req    = route_valid_i && (route_i == MY_ROUTE);
    // Nothing is acked or nacked outside an open event
    assign accept = event_open_i && ((route_data_i & CHECK_BITS) == '0);

    always_ff @(posedge aclk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            reply_valid_o   <= 1'b0;
            acknack_valid_o <= 1'b0;
        end else begin
            reply_valid_o   <= req;
            acknack_valid_o <= req && accept;
        end
    end

    always_ff @(posedge aclk_i) begin
        if (req) begin
            reply_data_o   <= accept ? route_data_i : `TURF_REJECT;
            acknack_data_o <= route_data_i[`TURF_ACK_W-1:0];
        end
    end

    // Each instance answers on its own port
    assign reply_port_o = (MY_ROUTE == turf_udp_pkg::ROUTE_ACK) ? `TURF_PORT_TA : `TURF_PORT_TN;

endmodule

//--- rtl/turf_event_ctrl_port.sv
`timescale 1ns/1ps
`include "turf_udp_consts.svh"

module turf_event_ctrl_port (
    input  logic                     aclk_i,
    input  logic                     arst_n_i,
    input  logic                     route_valid_i,
    input  turf_udp_pkg::route_e     route_i,
    input  turf_udp_pkg::payload_t   route_data_i,
    output logic                     reply_valid_o,
    output turf_udp_pkg::port_t      reply_port_o,
    output turf_udp_pkg::payload_t   reply_data_o,
    output logic                     event_open_o,
    output logic [`TURF_NFRAG_W-1:0] nfrag_count_o
);

    logic                     req;
    turf_udp_pkg::ctrl_op_e   op;
    logic [`TURF_NFRAG_W-1:0] nfrag_req;
    logic                     open_d;
    logic [`TURF_NFRAG_W-1:0] nfrag_d;
    logic                     err_d;
    turf_udp_pkg::payload_t   reply_d;

    assign req       = route_valid_i && (route_i == turf_udp_pkg::ROUTE_CTRL);
    assign op        = turf_udp_pkg::ctrl_op_e'(route_data_i[63:56]);
    assign nfrag_req = route_data_i[`TURF_NFRAG_W-1:0];

    // Next event state for this request
    always_comb begin
        open_d  = event_open_o;
        nfrag_d = nfrag_count_o;
        err_d   = 1'b0;
        case (op)
            turf_udp_pkg::OP_STATUS: begin
            end
            turf_udp_pkg::OP_OPEN:  open_d = 1'b1;
            turf_udp_pkg::OP_CLOSE: open_d = 1'b0;
            turf_udp_pkg::OP_SET_NFRAG: begin
                nfrag_d = (nfrag_req > `TURF_NFRAG_MAX) ? `TURF_NFRAG_MAX : nfrag_req;
            end
            default: err_d = 1'b1;
        endcase
    end

    // Reply reports the state after the update
    always_comb begin
        reply_d                         = '0;
        reply_d[63:56]                  = op;
        reply_d[`TURF_CTRL_ERR_BIT]     = err_d;
        reply_d[`TURF_NFRAG_W]          = open_d;
        reply_d[`TURF_NFRAG_W-1:0]      = nfrag_d;
    end

    always_ff @(posedge aclk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            reply_valid_o <= 1'b0;
            event_open_o  <= 1'b0;
            nfrag_count_o <= '0;
        end else begin
            reply_valid_o <= req;
            if (req) begin
                event_open_o  <= open_d;
                nfrag_count_o <= nfrag_d;
            end
        end
    end

    always_ff @(posedge aclk_i) begin
        if (req) begin
            reply_data_o <= reply_d;
        end
    end

    assign reply_port_o = `TURF_PORT_TC;

endmodule

//--- rtl/turf_udp_consts.svh
`ifndef TURF_UDP_CONSTS_SVH
`define TURF_UDP_CONSTS_SVH

// Field widths
`define TURF_PORT_W       16
`define TURF_PAYLOAD_W    64
`define TURF_ACK_W        16

// Inbound and reply ports, named after their ASCII tags
`define TURF_PORT_TA      16'd21601
`define TURF_PORT_TC      16'd21603
`define TURF_PORT_TN      16'd21614
`define TURF_PORT_TR      16'd21618
`define TURF_PORT_TW      16'd21623

// Low three bits ignored so that 21616-21623 all land on the read/write handler
`define TURF_RDWR_MASK    16'h0007

// A request is rejected if any of these payload bits is set
`define TURF_ACK_CHECK    64'h800000FF_FFF00000
`define TURF_NACK_CHECK   64'h000000FF_FFFFFFFF

// Event control limits
`define TURF_NFRAG_W      10
`define TURF_NFRAG_MAX    10'd1011
`define TURF_REG_ADDR_W   4

`define TURF_REJECT       {64{1'b1}}
`define TURF_CTRL_ERR_BIT 55

`endif

//--- rtl/turf_udp_pkg.sv
`include "turf_udp_consts.svh"

package turf_udp_pkg;

    typedef logic [`TURF_PORT_W-1:0]    port_t;
    typedef logic [`TURF_PAYLOAD_W-1:0] payload_t;

    // Which handler an inbound datagram goes to
    typedef enum logic [2:0] {
        ROUTE_NONE,
        ROUTE_RDWR,
        ROUTE_NACK,
        ROUTE_CTRL,
        ROUTE_ACK
    } route_e;

    // Control port opcode, top byte of the payload
    typedef enum logic [7:0] {
        OP_STATUS    = 8'd0,
        OP_OPEN      = 8'd1,
        OP_CLOSE     = 8'd2,
        OP_SET_NFRAG = 8'd3
    } ctrl_op_e;

endpackage

//--- rtl/turf_udp_rdwr.sv
`timescale 1ns/1ps
`include "turf_udp_consts.svh"

module turf_udp_rdwr (
    input  logic                   aclk_i,
    input  logic                   arst_n_i,
    input  logic                   route_valid_i,
    input  turf_udp_pkg::route_e   route_i,
    input  logic [2:0]             route_sub_i,
    input  turf_udp_pkg::payload_t route_data_i,
    output logic                   reply_valid_o,
    output turf_udp_pkg::port_t    reply_port_o,
    output turf_udp_pkg::payload_t reply_data_o
);

    localparam int                  DATA_W  = 32;
    localparam int                  NREGS   = 2 ** `TURF_REG_ADDR_W;
    localparam turf_udp_pkg::port_t RD_PORT = `TURF_PORT_TR;

    logic [DATA_W-1:0]           regs [NREGS];
    logic                        req;
    logic                        is_read;
    logic [`TURF_REG_ADDR_W-1:0] addr;
    logic [DATA_W-1:0]           wdata;
    turf_udp_pkg::payload_t      rd_word;

    assign req     = route_valid_i && (route_i == turf_udp_pkg::ROUTE_RDWR);
    // Only the exact read port reads, the rest of the range writes
    assign is_read = (route_sub_i == RD_PORT[2:0]);
    assign addr    = route_data_i[DATA_W +: `TURF_REG_ADDR_W];
    assign wdata   = route_data_i[DATA_W-1:0];

    always_comb begin
        rd_word                               = '0;
        rd_word[DATA_W +: `TURF_REG_ADDR_W]   = addr;
        rd_word[DATA_W-1:0]                   = regs[addr];
    end

    // Register file comes up cleared
    always_ff @(posedge aclk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (req && !is_read) begin
            regs[addr] <= wdata;
        end
    end

    always_ff @(posedge aclk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            reply_valid_o <= 1'b0;
        end else begin
            reply_valid_o <= req;
        end
    end

    always_ff @(posedge aclk_i) begin
        if (req) begin
            reply_port_o <= is_read ? `TURF_PORT_TR : `TURF_PORT_TW;
            // Writes echo the request word
            reply_data_o <= is_read ? rd_word : route_data_i;
        end
    end

endmodule

//--- rtl/turf_udp_wrap.sv
`timescale 1ns/1ps
`include "turf_udp_consts.svh"

module turf_udp_wrap (
    input  logic                     aclk_i,
    input  logic                     arst_n_i,
    input  logic                     udp_valid_i,
    input  turf_udp_pkg::port_t      udp_port_i,
    input  turf_udp_pkg::payload_t   udp_data_i,
    output logic                     reply_valid_o,
    output turf_udp_pkg::port_t      reply_port_o,
    output turf_udp_pkg::payload_t   reply_data_o,
    output logic                     ack_valid_o,
    output logic [`TURF_ACK_W-1:0]   ack_data_o,
    output logic                     nack_valid_o,
    output logic [`TURF_ACK_W-1:0]   nack_data_o,
    output logic                     event_open_o,
    output logic [`TURF_NFRAG_W-1:0] nfrag_count_o
);

    // Switch outputs, fanned out to every handler
    logic                   route_valid;
    turf_udp_pkg::route_e   route;
    logic [2:0]             route_sub;
    turf_udp_pkg::payload_t route_data;

    // Handler replies
    logic                   rdwr_valid, ctrl_valid, ack_valid, nack_valid;
    turf_udp_pkg::port_t    rdwr_port, ctrl_port, ack_port, nack_port;
    turf_udp_pkg::payload_t rdwr_data, ctrl_data, ack_data, nack_data;

    udp_port_switch u_switch (
        .aclk_i(aclk_i), .arst_n_i(arst_n_i),
        .udp_valid_i(udp_valid_i), .udp_port_i(udp_port_i), .udp_data_i(udp_data_i),
        .route_valid_o(route_valid), .route_o(route),
        .route_sub_o(route_sub), .route_data_o(route_data)
    );

    turf_udp_rdwr u_rdwr (
        .aclk_i(aclk_i), .arst_n_i(arst_n_i),
        .route_valid_i(route_valid), .route_i(route),
        .route_sub_i(route_sub), .route_data_i(route_data),
        .reply_valid_o(rdwr_valid), .reply_port_o(rdwr_port), .reply_data_o(rdwr_data)
    );

    turf_event_ctrl_port u_ctrlport (
        .aclk_i(aclk_i), .arst_n_i(arst_n_i),
        .route_valid_i(route_valid), .route_i(route), .route_data_i(route_data),
        .reply_valid_o(ctrl_valid), .reply_port_o(ctrl_port), .reply_data_o(ctrl_data),
        .event_open_o(event_open_o), .nfrag_count_o(nfrag_count_o)
    );

    // Ack and nack share one handler, differing only in check bits and port
    turf_acknack_port #(
        .CHECK_BITS(`TURF_ACK_CHECK),
        .MY_ROUTE(turf_udp_pkg::ROUTE_ACK)
    ) u_ackport (
        .aclk_i(aclk_i), .arst_n_i(arst_n_i),
        .route_valid_i(route_valid), .route_i(route), .route_data_i(route_data),
        .event_open_i(event_open_o),
        .reply_valid_o(ack_valid), .reply_port_o(ack_port), .reply_data_o(ack_data),
        .acknack_valid_o(ack_valid_o), .acknack_data_o(ack_data_o)
    );

    turf_acknack_port #(
        .CHECK_BITS(`TURF_NACK_CHECK),
        .MY_ROUTE(turf_udp_pkg::ROUTE_NACK)
    ) u_nackport (
        .aclk_i(aclk_i), .arst_n_i(arst_n_i),
        .route_valid_i(route_valid), .route_i(route), .route_data_i(route_data),
        .event_open_i(event_open_o),
        .reply_valid_o(nack_valid), .reply_port_o(nack_port), .reply_data_o(nack_data),
        .acknack_valid_o(nack_valid_o), .acknack_data_o(nack_data_o)
    );

    udp_reply_mux u_mux (
        .aclk_i(aclk_i), .arst_n_i(arst_n_i),
        .rdwr_reply_valid_i(rdwr_valid), .rdwr_reply_port_i(rdwr_port),
        .rdwr_reply_data_i(rdwr_data),
        .ctrl_reply_valid_i(ctrl_valid), .ctrl_reply_port_i(ctrl_port),
        .ctrl_reply_data_i(ctrl_data),
        .ack_reply_valid_i(ack_valid), .ack_reply_port_i(ack_port),
        .ack_reply_data_i(ack_data),
        .nack_reply_valid_i(nack_valid), .nack_reply_port_i(nack_port),
        .nack_reply_data_i(nack_data),
        .reply_valid_o(reply_valid_o), .reply_port_o(reply_port_o),
        .reply_data_o(reply_data_o)
    );

endmodule

//--- rtl/udp_port_switch.sv
`timescale 1ns/1ps
`include "turf_udp_consts.svh"

module udp_port_switch (
    input  logic                   aclk_i,
    input  logic                   arst_n_i,
    input  logic                   udp_valid_i,
    input  turf_udp_pkg::port_t    udp_port_i,
    input  turf_udp_pkg::payload_t udp_data_i,
    output logic                   route_valid_o,
    output turf_udp_pkg::route_e   route_o,
    output logic [2:0]             route_sub_o,
    output turf_udp_pkg::payload_t route_data_o
);

    turf_udp_pkg::route_e route_d;

    // Bits set in the mask are don't-care
    function automatic logic port_match(input turf_udp_pkg::port_t port,
                                        input turf_udp_pkg::port_t ref_port,
                                        input turf_udp_pkg::port_t mask);
        return ((port ^ ref_port) & ~mask) == '0;
    endfunction

    // Inbound table, checked in priority order
    always_comb begin
        if (port_match(udp_port_i, `TURF_PORT_TA, '0)) begin
            route_d = turf_udp_pkg::ROUTE_ACK;
        end else if (port_match(udp_port_i, `TURF_PORT_TC, '0)) begin
            route_d = turf_udp_pkg::ROUTE_CTRL;
        end else if (port_match(udp_port_i, `TURF_PORT_TN, '0)) begin
            route_d = turf_udp_pkg::ROUTE_NACK;
        end else if (port_match(udp_port_i, `TURF_PORT_TR, `TURF_RDWR_MASK)) begin
            route_d = turf_udp_pkg::ROUTE_RDWR;
        end else begin
            route_d = turf_udp_pkg::ROUTE_NONE;
        end
    end

    always_ff @(posedge aclk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            route_valid_o <= 1'b0;
            route_o       <= turf_udp_pkg::ROUTE_NONE;
        end else begin
            // Unmatched datagrams are simply dropped here
            route_valid_o <= udp_valid_i && (route_d != turf_udp_pkg::ROUTE_NONE);
            route_o       <= route_d;
        end
    end

    always_ff @(posedge aclk_i) begin
        route_sub_o  <= udp_port_i[2:0];
        route_data_o <= udp_data_i;
    end

endmodule

//--- rtl/udp_reply_mux.sv
`timescale 1ns/1ps
`include "turf_udp_consts.svh"

module udp_reply_mux (
    input  logic                   aclk_i,
    input  logic                   arst_n_i,
    input  logic                   rdwr_reply_valid_i,
    input  turf_udp_pkg::port_t    rdwr_reply_port_i,
    input  turf_udp_pkg::payload_t rdwr_reply_data_i,
    input  logic                   ctrl_reply_valid_i,
    input  turf_udp_pkg::port_t    ctrl_reply_port_i,
    input  turf_udp_pkg::payload_t ctrl_reply_data_i,
    input  logic                   ack_reply_valid_i,
    input  turf_udp_pkg::port_t    ack_reply_port_i,
    input  turf_udp_pkg::payload_t ack_reply_data_i,
    input  logic                   nack_reply_valid_i,
    input  turf_udp_pkg::port_t    nack_reply_port_i,
    input  turf_udp_pkg::payload_t nack_reply_data_i,
    output logic                   reply_valid_o,
    output turf_udp_pkg::port_t    reply_port_o,
    output turf_udp_pkg::payload_t reply_data_o
);

    logic                   any_valid;
    turf_udp_pkg::port_t    sel_port;
    turf_udp_pkg::payload_t sel_data;

    assign any_valid = rdwr_reply_valid_i | ctrl_reply_valid_i |
                       ack_reply_valid_i | nack_reply_valid_i;

    // Handlers share one latency so at most one strobe is ever high
    always_comb begin
        if (rdwr_reply_valid_i) begin
            sel_port = rdwr_reply_port_i;
            sel_data = rdwr_reply_data_i;
        end else if (ctrl_reply_valid_i) begin
            sel_port = ctrl_reply_port_i;
            sel_data = ctrl_reply_data_i;
        end else if (ack_reply_valid_i) begin
            sel_port = ack_reply_port_i;
            sel_data = ack_reply_data_i;
        end else begin
            sel_port = nack_reply_port_i;
            sel_data = nack_reply_data_i;
        end
    end

    always_ff @(posedge aclk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            reply_valid_o <= 1'b0;
        end else begin
            reply_valid_o <= any_valid;
        end
    end

    always_ff @(posedge aclk_i) begin
        if (any_valid) begin
            reply_port_o <= sel_port;
            reply_data_o <= sel_data;
        end
    end

endmodule

//--- test/turf_udp_wrap_checker.sv
`timescale 1ns/1ps
`include "turf_udp_consts.svh"

module turf_udp_wrap_checker (
    input logic                     aclk_i,
    input logic                     arst_n_i,
    input logic                     rdwr_valid_i,
    input logic                     ctrl_valid_i,
    input logic                     ack_src_valid_i,
    input logic                     nack_src_valid_i,
    input logic                     reply_valid_i,
    input turf_udp_pkg::port_t      reply_port_i,
    input logic                     ack_valid_i,
    input logic                     nack_valid_i,
    input logic                     event_open_i,
    input logic [`TURF_NFRAG_W-1:0] nfrag_count_i
);

    // Handlers share one latency, so replies never collide at the mux
    one_reply_source: assert property (@(posedge aclk_i) disable iff (!arst_n_i)
        $onehot0({rdwr_valid_i, ctrl_valid_i, ack_src_valid_i, nack_src_valid_i}))
        else $error("more than one handler reply in the same cycle");

    known_reply_port: assert property (@(posedge aclk_i) disable iff (!arst_n_i)
        reply_valid_i |-> (reply_port_i inside {`TURF_PORT_TA, `TURF_PORT_TC,
                                                `TURF_PORT_TN, `TURF_PORT_TR, `TURF_PORT_TW}))
        else $error("reply on a port outside the reply table");

    acknack_needs_open: assert property (@(posedge aclk_i) disable iff (!arst_n_i)
        (ack_valid_i || nack_valid_i) |-> event_open_i)
        else $error("ack or nack strobe while the event is closed");

    nfrag_in_range: assert property (@(posedge aclk_i) disable iff (!arst_n_i)
        nfrag_count_i <= `TURF_NFRAG_MAX)
        else $error("fragment count above its limit");

endmodule

bind turf_udp_wrap turf_udp_wrap_checker i_checker (
    .aclk_i(aclk_i), .arst_n_i(arst_n_i),
    .rdwr_valid_i(rdwr_valid), .ctrl_valid_i(ctrl_valid),
    .ack_src_valid_i(ack_valid), .nack_src_valid_i(nack_valid),
    .reply_valid_i(reply_valid_o), .reply_port_i(reply_port_o),
    .ack_valid_i(ack_valid_o), .nack_valid_i(nack_valid_o),
    .event_open_i(event_open_o), .nfrag_count_i(nfrag_count_o)
);

//--- test/turf_udp_wrap_tb.sv
`timescale 1ns/1ps
`include "turf_udp_consts.svh"

module turf_udp_wrap_tb;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 3;
    localparam int NUM_CYCLES   = 3000;
    localparam int WATCHDOG_NS  = (RESET_CYCLES + NUM_CYCLES + 50) * CLK_PERIOD;

    typedef struct {
        int                     due;
        turf_udp_pkg::port_t    port;
        turf_udp_pkg::payload_t data;
    } exp_reply_t;

    typedef struct {
        int                     due;
        logic                   is_nack;
        logic [`TURF_ACK_W-1:0] data;
    } exp_acknack_t;

    typedef struct {
        int                       due;
        logic                     open;
        logic [`TURF_NFRAG_W-1:0] nfrag;
    } exp_state_t;

    logic                     aclk = 1'b0;
    logic                     arst_n = 1'b0;
    logic                     udp_valid = 1'b0;
    turf_udp_pkg::port_t      udp_port = '0;
    turf_udp_pkg::payload_t   udp_data = '0;
    logic                     reply_valid;
    turf_udp_pkg::port_t      reply_port;
    turf_udp_pkg::payload_t   reply_data;
    logic                     ack_valid;
    logic [`TURF_ACK_W-1:0]   ack_data;
    logic                     nack_valid;
    logic [`TURF_ACK_W-1:0]   nack_data;
    logic                     event_open;
    logic [`TURF_NFRAG_W-1:0] nfrag_count;

    // Reference model state, updated in arrival order
    logic [31:0]              m_regs [16];
    logic                     m_open = 1'b0;
    logic [`TURF_NFRAG_W-1:0] m_nfrag = '0;
    logic                     cur_open = 1'b0;
    logic [`TURF_NFRAG_W-1:0] cur_nfrag = '0;

    exp_reply_t   exp_rep[$];
    exp_acknack_t exp_ack[$];
    exp_state_t   exp_st[$];

    int cyc = 0;
    int n_checks = 0;
    int n_errors = 0;
    bit checking = 1'b0;

    turf_udp_wrap i_dut (
        .aclk_i(aclk), .arst_n_i(arst_n),
        .udp_valid_i(udp_valid), .udp_port_i(udp_port), .udp_data_i(udp_data),
        .reply_valid_o(reply_valid), .reply_port_o(reply_port), .reply_data_o(reply_data),
        .ack_valid_o(ack_valid), .ack_data_o(ack_data),
        .nack_valid_o(nack_valid), .nack_data_o(nack_data),
        .event_open_o(event_open), .nfrag_count_o(nfrag_count)
    );

    always #(CLK_PERIOD / 2) aclk = ~aclk;

    always @(posedge aclk) cyc <= cyc + 1;

    // Expected results of one datagram sent in the current cycle
    task automatic model_datagram(input turf_udp_pkg::port_t port,
                                  input turf_udp_pkg::payload_t data);
        turf_udp_pkg::payload_t check;
        logic                   accept;
        logic [7:0]             op;
        logic                   err;
        logic [3:0]             addr;
        addr = data[35:32];
        if (port == `TURF_PORT_TA || port == `TURF_PORT_TN) begin
            check  = (port == `TURF_PORT_TA) ? `TURF_ACK_CHECK : `TURF_NACK_CHECK;
            accept = m_open && ((data & check) == 64'd0);
            exp_rep.push_back('{cyc + 3, port, accept ? data : `TURF_REJECT});
            if (accept) begin
                exp_ack.push_back('{cyc + 2, port == `TURF_PORT_TN, data[15:0]});
            end
        end else if (port == `TURF_PORT_TC) begin
            op  = data[63:56];
            err = 1'b0;
            case (op)
                8'd0: begin
                    // Status only
                end
                8'd1: m_open = 1'b1;
                8'd2: m_open = 1'b0;
                8'd3: m_nfrag = (data[9:0] > `TURF_NFRAG_MAX) ? `TURF_NFRAG_MAX : data[9:0];
                default: err = 1'b1;
            endcase
            exp_rep.push_back('{cyc + 3, port, {op, err, 44'd0, m_open, m_nfrag}});
            exp_st.push_back('{cyc + 2, m_open, m_nfrag});
        end else if (port >= 16'd21616 && port <= 16'd21623) begin
            if (port == 16'd21618) begin
                exp_rep.push_back('{cyc + 3, port, {28'd0, addr, m_regs[addr]}});
            end else begin
                m_regs[addr] = data[31:0];
                exp_rep.push_back('{cyc + 3, 16'd21623, data});
            end
        end
    endtask

    task automatic compare_reply(input turf_udp_pkg::port_t got_port,
                                 input turf_udp_pkg::payload_t got_data,
                                 input turf_udp_pkg::port_t exp_port,
                                 input turf_udp_pkg::payload_t exp_data);
        n_checks++;
        if (got_port !== exp_port || got_data !== exp_data) begin
            n_errors++;
            $display("mismatch at %0t: reply port %0d data %h, expected port %0d data %h",
                     $time, got_port, got_data, exp_port, exp_data);
        end
    endtask

    task automatic compare_acknack(input logic got_ack, input logic got_nack,
                                   input logic [`TURF_ACK_W-1:0] got_data,
                                   input logic exp_nack,
                                   input logic [`TURF_ACK_W-1:0] exp_data);
        n_checks++;
        if (got_ack !== !exp_nack || got_nack !== exp_nack || got_data !== exp_data) begin
            n_errors++;
            $display("mismatch at %0t: ack %b nack %b data %h, expected %s data %h",
                     $time, got_ack, got_nack, got_data, exp_nack ? "nack" : "ack", exp_data);
        end
    endtask

    task automatic compare_state(input logic got_open,
                                 input logic [`TURF_NFRAG_W-1:0] got_nfrag,
                                 input logic exp_open,
                                 input logic [`TURF_NFRAG_W-1:0] exp_nfrag);
        n_checks++;
        if (got_open !== exp_open || got_nfrag !== exp_nfrag) begin
            n_errors++;
            $display("mismatch at %0t: event open %b nfrag %0d, expected open %b nfrag %0d",
                     $time, got_open, got_nfrag, exp_open, exp_nfrag);
        end
    endtask

    // Outputs are stable at the falling edge
    task automatic check_outputs();
        exp_reply_t   r;
        exp_acknack_t a;
        exp_state_t   s;
        if (reply_valid) begin
            if (exp_rep.size() == 0 || exp_rep[0].due != cyc) begin
                n_errors++;
                $display("unexpected reply on port %0d at %0t", reply_port, $time);
            end else begin
                r = exp_rep.pop_front();
                compare_reply(reply_port, reply_data, r.port, r.data);
            end
        end else if (exp_rep.size() != 0 && exp_rep[0].due == cyc) begin
            n_errors++;
            $display("expected reply on port %0d missing at %0t", exp_rep[0].port, $time);
            r = exp_rep.pop_front();
        end
        if (ack_valid || nack_valid) begin
            if (exp_ack.size() == 0 || exp_ack[0].due != cyc) begin
                n_errors++;
                $display("unexpected ack or nack strobe at %0t", $time);
            end else begin
                a = exp_ack.pop_front();
                compare_acknack(ack_valid, nack_valid, a.is_nack ? nack_data : ack_data,
                                a.is_nack, a.data);
            end
        end else if (exp_ack.size() != 0 && exp_ack[0].due == cyc) begin
            n_errors++;
            $display("expected ack or nack strobe missing at %0t", $time);
            a = exp_ack.pop_front();
        end
        while (exp_st.size() != 0 && exp_st[0].due <= cyc) begin
            s         = exp_st.pop_front();
            cur_open  = s.open;
            cur_nfrag = s.nfrag;
        end
        compare_state(event_open, nfrag_count, cur_open, cur_nfrag);
    endtask

    always @(negedge aclk) begin
        if (checking) begin
            check_outputs();
        end
    end

    // Mostly known ports, with payloads leaning toward legal requests
    task automatic send_random();
        turf_udp_pkg::port_t    port;
        turf_udp_pkg::payload_t data;
        turf_udp_pkg::payload_t r;
        logic [7:0]             op;
        logic [9:0]             nfrag;
        logic [3:0]             addr;
        r     = {$urandom, $urandom};
        op    = ($urandom_range(0, 9) < 8) ? 8'($urandom_range(0, 3)) : 8'($urandom);
        nfrag = ($urandom_range(0, 1) == 0) ? 10'($urandom_range(990, 1023)) : r[9:0];
        addr  = ($urandom_range(0, 1) == 0) ? 4'($urandom_range(0, 3)) : r[35:32];
        case ($urandom_range(0, 9))
            0, 1: begin
                port = `TURF_PORT_TA;
                data = ($urandom_range(0, 2) != 0) ? (r & ~`TURF_ACK_CHECK) : r;
            end
            2, 3: begin
                port = `TURF_PORT_TC;
                data = {op, r[55:10], nfrag};
            end
            4: begin
                port = `TURF_PORT_TN;
                data = ($urandom_range(0, 2) != 0) ? (r & ~`TURF_NACK_CHECK) : r;
            end
            5, 6: begin
                port = `TURF_PORT_TR;
                data = {r[63:36], addr, r[31:0]};
            end
            7, 8: begin
                port = 16'd21616 + 16'($urandom_range(0, 7));
                data = {r[63:36], addr, r[31:0]};
            end
            default: begin
                port = 16'($urandom);
                data = r;
            end
        endcase
        udp_valid = 1'b1;
        udp_port  = port;
        udp_data  = data;
        model_datagram(port, data);
    endtask

    initial begin
        void'($urandom(32'h859e_1858));
        for (int i = 0; i < 16; i++) begin
            m_regs[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge aclk);
        #2;
        arst_n   = 1'b1;
        checking = 1'b1;
        for (int i = 0; i < NUM_CYCLES; i++) begin
            @(posedge aclk);
            #2;
            if ($urandom_range(0, 4) != 0) begin
                send_random();
            end else begin
                // Junk on the bus while the strobe is low
                udp_valid = 1'b0;
                udp_port  = 16'($urandom);
                udp_data  = {$urandom, $urandom};
            end
        end
        @(posedge aclk);
        #2;
        udp_valid = 1'b0;
        repeat (6) @(posedge aclk);
        @(negedge aclk);
        #1;
        if (exp_rep.size() != 0 || exp_ack.size() != 0) begin
            n_errors++;
            $display("expected results still pending when the test ended");
        end
        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog timeout after %0d ns, the test did not complete", WATCHDOG_NS);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule
